// ==== common/core_pkg.sv ====
package core_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int reg_count  = 32;
    localparam int sel_width  = 4;   // one bit per byte lane

    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

    // zero must stay nop, bubbles rely on it
    typedef enum logic [3:0] {
        exe_nop = 4'd0,
        exe_add,
        exe_sub,
        exe_and,
        exe_or,
        exe_xor,
        exe_slt,
        exe_lui,
        exe_lw,
        exe_lb,
        exe_sw,
        exe_sb
    } exe_op_t;

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

    localparam int inst_width = 32;

    // instruction field positions
    localparam int op_lsb      = 26;
    localparam int op_width    = 6;
    localparam int rs_lsb      = 21;
    localparam int rt_lsb      = 16;
    localparam int rd_lsb      = 11;
    localparam int reg_width   = 5;
    localparam int shamt_lsb   = 6;
    localparam int shamt_width = 5;
    localparam int funct_lsb   = 0;
    localparam int funct_width = 6;
    localparam int imm_lsb     = 0;
    localparam int imm_width   = 16;

    // primary opcodes
    localparam logic [op_width-1:0] op_special = 6'b000000;
    localparam logic [op_width-1:0] op_beq     = 6'b000100;
    localparam logic [op_width-1:0] op_bne     = 6'b000101;
    localparam logic [op_width-1:0] op_addiu   = 6'b001001;
    localparam logic [op_width-1:0] op_andi    = 6'b001100;
    localparam logic [op_width-1:0] op_ori     = 6'b001101;
    localparam logic [op_width-1:0] op_lui     = 6'b001111;
    localparam logic [op_width-1:0] op_lb      = 6'b100000;
    localparam logic [op_width-1:0] op_lw      = 6'b100011;
    localparam logic [op_width-1:0] op_sb      = 6'b101000;
    localparam logic [op_width-1:0] op_sw      = 6'b101011;

    // function codes under op_special
    localparam logic [funct_width-1:0] fn_addu = 6'b100001;
    localparam logic [funct_width-1:0] fn_subu = 6'b100011;
    localparam logic [funct_width-1:0] fn_and  = 6'b100100;
    localparam logic [funct_width-1:0] fn_or   = 6'b100101;
    localparam logic [funct_width-1:0] fn_xor  = 6'b100110;
    localparam logic [funct_width-1:0] fn_slt  = 6'b101010;

endpackage

// ==== decode/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic [core_pkg::addr_width-1:0] pc_i,
    input  logic [isa_pkg::inst_width-1:0]  inst_i,
    input  logic [core_pkg::data_width-1:0] rs_data_i,
    input  logic [core_pkg::data_width-1:0] rt_data_i,
    input  core_pkg::reg_addr_t             ex_waddr_i,
    input  logic                            ex_is_load_i,
    output core_pkg::reg_addr_t             rs_addr_o,
    output core_pkg::reg_addr_t             rt_addr_o,
    output logic                            rs_read_o,
    output logic                            rt_read_o,
    output core_pkg::exe_op_t               op_o,
    output logic [core_pkg::data_width-1:0] op1_o,
    output logic [core_pkg::data_width-1:0] op2_o,
    output logic [core_pkg::data_width-1:0] store_data_o,
    output core_pkg::reg_addr_t             waddr_o,
    output logic                            wreg_o,
    output logic                            branch_o,
    output logic [core_pkg::addr_width-1:0] branch_target_o,
    output logic                            stall_req_o
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [op_width-1:0]    opcode;
    logic [funct_width-1:0] funct;
    reg_addr_t              rd_addr;
    logic [imm_width-1:0]   imm;
    logic [data_width-1:0]  imm_sext;
    logic [data_width-1:0]  imm_zext;
    logic                   use_imm;
    logic                   zext_imm;
    logic                   is_beq;
    logic                   is_bne;
    logic                   taken;

    assign opcode    = inst_i[op_lsb +: op_width];
    assign funct     = inst_i[funct_lsb +: funct_width];
    assign rs_addr_o = inst_i[rs_lsb +: reg_width];
    assign rt_addr_o = inst_i[rt_lsb +: reg_width];
    assign rd_addr   = inst_i[rd_lsb +: reg_width];
    assign imm       = inst_i[imm_lsb +: imm_width];
    assign imm_sext  = {{(data_width-imm_width){imm[imm_width-1]}}, imm};
    assign imm_zext  = {{(data_width-imm_width){1'b0}}, imm};

    always_comb begin
        op_o      = exe_nop;
        rs_read_o = 1'b0;
        rt_read_o = 1'b0;
        waddr_o   = rt_addr_o;
        wreg_o    = 1'b0;
        use_imm   = 1'b0;
        zext_imm  = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        case (opcode)
            op_special: begin
                rs_read_o = 1'b1;
                rt_read_o = 1'b1;
                waddr_o   = rd_addr;
                wreg_o    = 1'b1;
                case (funct)
                    fn_addu: op_o = exe_add;
                    fn_subu: op_o = exe_sub;
                    fn_and:  op_o = exe_and;
                    fn_or:   op_o = exe_or;
                    fn_xor:  op_o = exe_xor;
                    fn_slt:  op_o = exe_slt;
                    default: begin   // includes sll 0 as nop
                        rs_read_o = 1'b0;
                        rt_read_o = 1'b0;
                        wreg_o    = 1'b0;
                    end
                endcase
            end
            op_addiu: {op_o, rs_read_o, wreg_o, use_imm} = {exe_add, 3'b111};
            op_andi:  {op_o, rs_read_o, wreg_o, use_imm, zext_imm} = {exe_and, 4'b1111};
            op_ori:   {op_o, rs_read_o, wreg_o, use_imm, zext_imm} = {exe_or, 4'b1111};
            op_lui:   {op_o, wreg_o, use_imm, zext_imm} = {exe_lui, 3'b111};
            op_lw:    {op_o, rs_read_o, wreg_o, use_imm} = {exe_lw, 3'b111};
            op_lb:    {op_o, rs_read_o, wreg_o, use_imm} = {exe_lb, 3'b111};
            op_sw:    {op_o, rs_read_o, rt_read_o, use_imm} = {exe_sw, 3'b111};
            op_sb:    {op_o, rs_read_o, rt_read_o, use_imm} = {exe_sb, 3'b111};
            op_beq:   {rs_read_o, rt_read_o, is_beq} = 3'b111;
            op_bne:   {rs_read_o, rt_read_o, is_bne} = 3'b111;
            default:  ;
        endcase
    end

    assign op1_o        = rs_data_i;
    assign op2_o        = !use_imm ? rt_data_i : (zext_imm ? imm_zext : imm_sext);
    assign store_data_o = rt_data_i;

    // operands already carry forwarded values
    assign taken = (is_beq && rs_data_i == rt_data_i) || (is_bne && rs_data_i != rt_data_i);
    assign branch_target_o = pc_i + addr_width'(4) + {imm_sext[addr_width-3:0], 2'b00};

    // load result not ready until MEM
    assign stall_req_o = ex_is_load_i && ex_waddr_i != '0 &&
                         ((rs_read_o && rs_addr_o == ex_waddr_i) ||
                          (rt_read_o && rt_addr_o == ex_waddr_i));
    assign branch_o    = taken && !stall_req_o;

endmodule

// ==== decode/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            ex_we_i,
    input  core_pkg::reg_addr_t             ex_waddr_i,
    input  logic [core_pkg::data_width-1:0] ex_wdata_i,
    input  logic                            mem_we_i,
    input  core_pkg::reg_addr_t             mem_waddr_i,
    input  logic [core_pkg::data_width-1:0] mem_wdata_i,
    input  logic                            wb_we_i,
    input  core_pkg::reg_addr_t             wb_waddr_i,
    input  logic [core_pkg::data_width-1:0] wb_wdata_i,
    input  core_pkg::reg_addr_t             raddr1_i,
    input  logic                            re1_i,
    input  core_pkg::reg_addr_t             raddr2_i,
    input  logic                            re2_i,
    output logic [core_pkg::data_width-1:0] rdata1_o,
    output logic [core_pkg::data_width-1:0] rdata2_o
);
    import core_pkg::*;

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (!reset_i && wb_we_i && wb_waddr_i != '0) begin
            regs[wb_waddr_i] <= wb_wdata_i;
        end
    end

    // youngest producer wins
    function automatic logic [data_width-1:0] fwd_read(reg_addr_t addr, logic re);
        if (!re || addr == '0)                return '0;
        else if (ex_we_i && ex_waddr_i == addr)   return ex_wdata_i;
        else if (mem_we_i && mem_waddr_i == addr) return mem_wdata_i;
        else if (wb_we_i && wb_waddr_i == addr)   return wb_wdata_i;
        else                                      return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = fwd_read(raddr1_i, re1_i);
        rdata2_o = fwd_read(raddr2_i, re2_i);
    end

endmodule

// ==== filelist.f ====
+incdir+test
common/isa_pkg.sv
common/core_pkg.sv
src/pipe_reg.sv
src/pc_reg.sv
decode/regfile.sv
decode/id_stage.sv
src/ex_stage.sv
src/mem_stage.sv
src/openmips.sv
test/tb_openmips.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_openmips -o sim_openmips

./obj_dir/sim_openmips > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  core_pkg::exe_op_t               op_i,
    input  logic [core_pkg::data_width-1:0] op1_i,
    input  logic [core_pkg::data_width-1:0] op2_i,
    input  core_pkg::reg_addr_t             waddr_i,
    input  logic                            wreg_i,
    output logic [core_pkg::data_width-1:0] result_o,
    output core_pkg::reg_addr_t             waddr_o,
    output logic                            wreg_o,
    output logic                            is_load_o
);
    import core_pkg::*;

    always_comb begin
        case (op_i)
            exe_add, exe_lw, exe_lb,
            exe_sw, exe_sb: result_o = op1_i + op2_i;   // address for memory ops
            exe_sub:        result_o = op1_i - op2_i;
            exe_and:        result_o = op1_i & op2_i;
            exe_or:         result_o = op1_i | op2_i;
            exe_xor:        result_o = op1_i ^ op2_i;
            exe_slt:        result_o = data_width'($signed(op1_i) < $signed(op2_i));
            exe_lui:        result_o = {op2_i[data_width/2-1:0], {(data_width/2){1'b0}}};
            default:        result_o = '0;
        endcase
    end

    assign is_load_o = (op_i == exe_lw) || (op_i == exe_lb);
    assign waddr_o   = waddr_i;
    assign wreg_o    = wreg_i;

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  core_pkg::exe_op_t               op_i,
    input  logic [core_pkg::addr_width-1:0] addr_i,
    input  logic [core_pkg::data_width-1:0] store_data_i,
    input  logic [core_pkg::data_width-1:0] result_i,
    input  core_pkg::reg_addr_t             waddr_i,
    input  logic                            wreg_i,
    input  logic [core_pkg::data_width-1:0] ram_data_i,
    output logic                            ram_ce_o,
    output logic                            ram_we_o,
    output logic [core_pkg::sel_width-1:0]  ram_sel_o,
    output logic [core_pkg::addr_width-1:0] ram_addr_o,
    output logic [core_pkg::data_width-1:0] ram_wdata_o,
    output logic [core_pkg::data_width-1:0] wdata_o,
    output core_pkg::reg_addr_t             waddr_o,
    output logic                            wreg_o
);
    import core_pkg::*;

    logic [1:0]           lane;
    logic [7:0]           load_byte;
    logic [sel_width-1:0] byte_sel;

    // big-endian, address 0 is the top byte
    assign lane      = ~addr_i[1:0];
    assign load_byte = ram_data_i[{lane, 3'b000} +: 8];
    assign byte_sel  = 4'b1000 >> addr_i[1:0];

    always_comb begin
        ram_ce_o    = 1'b0;
        ram_we_o    = 1'b0;
        ram_sel_o   = '0;
        ram_wdata_o = '0;
        wdata_o     = result_i;
        case (op_i)
            exe_lw: begin
                ram_ce_o  = 1'b1;
                ram_sel_o = '1;
                wdata_o   = ram_data_i;
            end
            exe_lb: begin
                ram_ce_o  = 1'b1;
                ram_sel_o = byte_sel;
                wdata_o   = {{(data_width-8){load_byte[7]}}, load_byte};
            end
            exe_sw: begin
                ram_ce_o    = 1'b1;
                ram_we_o    = 1'b1;
                ram_sel_o   = '1;
                ram_wdata_o = store_data_i;
            end
            exe_sb: begin
                ram_ce_o    = 1'b1;
                ram_we_o    = 1'b1;
                ram_sel_o   = byte_sel;
                ram_wdata_o = {(data_width/8){store_data_i[7:0]}};   // same byte on every lane
            end
            default: ;
        endcase
    end

    assign ram_addr_o = addr_i;
    assign waddr_o    = waddr_i;
    assign wreg_o     = wreg_i;

endmodule

// ==== src/openmips.sv ====
`timescale 1ns/1ps

module openmips #(
    parameter logic [core_pkg::addr_width-1:0] reset_pc = '0
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [isa_pkg::inst_width-1:0]  rom_data_i,
    input  logic [core_pkg::data_width-1:0] ram_data_i,
    output logic                            rom_ce_o,
    output logic [core_pkg::addr_width-1:0] rom_addr_o,
    output logic                            ram_ce_o,
    output logic                            ram_we_o,
    output logic [core_pkg::sel_width-1:0]  ram_sel_o,
    output logic [core_pkg::addr_width-1:0] ram_addr_o,
    output logic [core_pkg::data_width-1:0] ram_wdata_o
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        logic [inst_width-1:0] inst;
    } if_id_t;

    typedef struct packed {
        exe_op_t               op;
        logic [data_width-1:0] op1;
        logic [data_width-1:0] op2;
        logic [data_width-1:0] store_data;
        reg_addr_t             waddr;
        logic                  wreg;
    } id_ex_t;

    typedef struct packed {
        exe_op_t               op;
        logic [data_width-1:0] result;      // also the load/store address
        logic [data_width-1:0] store_data;
        reg_addr_t             waddr;
        logic                  wreg;
    } ex_mem_t;

    typedef struct packed {
        logic [data_width-1:0] wdata;
        reg_addr_t             waddr;
        logic                  wreg;
    } mem_wb_t;

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    logic                  stall;
    logic                  branch;
    logic [addr_width-1:0] branch_target;
    reg_addr_t             rs_addr;
    reg_addr_t             rt_addr;
    logic                  rs_read;
    logic                  rt_read;
    logic [data_width-1:0] rs_data;
    logic [data_width-1:0] rt_data;
    logic                  ex_is_load;

    pc_reg #(.reset_pc(reset_pc)) u_pc_reg (
        .clk             (clk),
        .reset_i         (reset_i),
        .hold_i          (stall),
        .branch_i        (branch),
        .branch_target_i (branch_target),
        .pc_o            (rom_addr_o),
        .ce_o            (rom_ce_o)
    );

    assign if_id_d = '{pc: rom_addr_o, inst: rom_ce_o ? rom_data_i : '0};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .reset_i(reset_i), .hold_i(stall), .bubble_i(1'b0),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    id_stage u_id_stage (
        .pc_i            (if_id_q.pc),
        .inst_i          (if_id_q.inst),
        .rs_data_i       (rs_data),
        .rt_data_i       (rt_data),
        .ex_waddr_i      (ex_mem_d.waddr),
        .ex_is_load_i    (ex_is_load),
        .rs_addr_o       (rs_addr),
        .rt_addr_o       (rt_addr),
        .rs_read_o       (rs_read),
        .rt_read_o       (rt_read),
        .op_o            (id_ex_d.op),
        .op1_o           (id_ex_d.op1),
        .op2_o           (id_ex_d.op2),
        .store_data_o    (id_ex_d.store_data),
        .waddr_o         (id_ex_d.waddr),
        .wreg_o          (id_ex_d.wreg),
        .branch_o        (branch),
        .branch_target_o (branch_target),
        .stall_req_o     (stall)
    );

    regfile u_regfile (
        .clk         (clk),
        .reset_i     (reset_i),
        .ex_we_i     (ex_mem_d.wreg),
        .ex_waddr_i  (ex_mem_d.waddr),
        .ex_wdata_i  (ex_mem_d.result),
        .mem_we_i    (mem_wb_d.wreg),
        .mem_waddr_i (mem_wb_d.waddr),
        .mem_wdata_i (mem_wb_d.wdata),
        .wb_we_i     (mem_wb_q.wreg),
        .wb_waddr_i  (mem_wb_q.waddr),
        .wb_wdata_i  (mem_wb_q.wdata),
        .raddr1_i    (rs_addr),
        .re1_i       (rs_read),
        .raddr2_i    (rt_addr),
        .re2_i       (rt_read),
        .rdata1_o    (rs_data),
        .rdata2_o    (rt_data)
    );

    // load-use bubble goes in here
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .reset_i(reset_i), .hold_i(1'b0), .bubble_i(stall),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    ex_stage u_ex_stage (
        .op_i      (id_ex_q.op),
        .op1_i     (id_ex_q.op1),
        .op2_i     (id_ex_q.op2),
        .waddr_i   (id_ex_q.waddr),
        .wreg_i    (id_ex_q.wreg),
        .result_o  (ex_mem_d.result),
        .waddr_o   (ex_mem_d.waddr),
        .wreg_o    (ex_mem_d.wreg),
        .is_load_o (ex_is_load)
    );

    assign ex_mem_d.op         = id_ex_q.op;
    assign ex_mem_d.store_data = id_ex_q.store_data;

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .reset_i(reset_i), .hold_i(1'b0), .bubble_i(1'b0),
        .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    mem_stage u_mem_stage (
        .op_i         (ex_mem_q.op),
        .addr_i       (ex_mem_q.result),
        .store_data_i (ex_mem_q.store_data),
        .result_i     (ex_mem_q.result),
        .waddr_i      (ex_mem_q.waddr),
        .wreg_i       (ex_mem_q.wreg),
        .ram_data_i   (ram_data_i),
        .ram_ce_o     (ram_ce_o),
        .ram_we_o     (ram_we_o),
        .ram_sel_o    (ram_sel_o),
        .ram_addr_o   (ram_addr_o),
        .ram_wdata_o  (ram_wdata_o),
        .wdata_o      (mem_wb_d.wdata),
        .waddr_o      (mem_wb_d.waddr),
        .wreg_o       (mem_wb_d.wreg)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .reset_i(reset_i), .hold_i(1'b0), .bubble_i(1'b0),
        .d_i(mem_wb_d), .q_o(mem_wb_q)
    );

endmodule

// ==== src/pc_reg.sv ====
`timescale 1ns/1ps

module pc_reg #(
    parameter logic [core_pkg::addr_width-1:0] reset_pc = '0
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            hold_i,
    input  logic                            branch_i,
    input  logic [core_pkg::addr_width-1:0] branch_target_i,
    output logic [core_pkg::addr_width-1:0] pc_o,
    output logic                            ce_o
);
    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ce_o <= 1'b0;
            pc_o <= reset_pc;
        end else begin
            ce_o <= 1'b1;
            // first enabled cycle fetches reset_pc
            if (ce_o && !hold_i) begin
                if (branch_i) begin
                    pc_o <= branch_target_i;
                end else begin
                    pc_o <= pc_o + addr_width'(4);
                end
            end
        end
    end

endmodule

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            if (bubble_i) begin
                q_o <= '0;   // all zero is a no-op
            end else begin
                q_o <= d_i;
            end
        end
    end

endmodule

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [31:0] data;
} store_t;

logic [31:0] lfsr_state = 32'he89b;
store_t      exp_q[$];
logic [31:0] ref_ram [ram_depth];
logic [31:0] halt_pc;
int          prog_len;
int          ref_steps;

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [4:0] pick_reg();
    logic [2:0] v;
    v = 3'(rand_bits(3));
    return (v == 3'd0) ? 5'd7 : {2'b00, v};   // registers 1 to 7
endfunction

function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                      logic [4:0] rd);
    return {op_special, rs, rt, rd, 5'b00000, fn};
endfunction

function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                      logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic void emit(logic [31:0] inst);
    rom[int'(reset_pc[9:2]) + prog_len] = inst;
    prog_len++;
endfunction

function automatic void emit_halt();
    halt_pc = reset_pc + 32'(prog_len * 4);
    emit(enc_i(op_beq, 5'd0, 5'd0, 16'hffff));
    emit(32'h0);
endfunction

// walks the rom image in program order with delay slots
function automatic void run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] next;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] ea;
    logic [31:0] w;
    logic [31:0] d;
    logic [3:0]  sel;
    logic [4:0]  rt;
    logic [4:0]  rd;
    exp_q.delete();
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    pc = reset_pc;
    npc = pc + 32'd4;
    ref_steps = 0;
    while (ref_steps < 4000) begin
        inst = rom[pc[9:2]];
        if (inst == enc_i(op_beq, 5'd0, 5'd0, 16'hffff)) break;
        next = npc + 32'd4;
        a = regs[inst[25:21]];
        b = regs[inst[20:16]];
        rt = inst[20:16];
        rd = inst[15:11];
        sx = {{16{inst[15]}}, inst[15:0]};
        zx = {16'h0000, inst[15:0]};
        ea = a + sx;
        case (inst[31:26])
            op_special: begin
                case (inst[5:0])
                    fn_addu: regs[rd] = a + b;
                    fn_subu: regs[rd] = a - b;
                    fn_and:  regs[rd] = a & b;
                    fn_or:   regs[rd] = a | b;
                    fn_xor:  regs[rd] = a ^ b;
                    fn_slt:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            op_addiu: regs[rt] = a + sx;
            op_andi:  regs[rt] = a & zx;
            op_ori:   regs[rt] = a | zx;
            op_lui:   regs[rt] = {inst[15:0], 16'h0000};
            op_lw:    regs[rt] = ref_ram[ea[7:2]];
            op_lb: begin
                w = ref_ram[ea[7:2]] >> (8 * (3 - int'(ea[1:0])));   // byte 0 is msb
                regs[rt] = {{24{w[7]}}, w[7:0]};
            end
            op_sw, op_sb: begin
                sel = (inst[31:26] == op_sw) ? 4'b1111 : (4'b1000 >> ea[1:0]);
                d = (inst[31:26] == op_sw) ? b : {4{b[7:0]}};
                exp_q.push_back(store_t'{addr: ea, sel: sel, data: d});
                for (int k = 0; k < 4; k++) begin
                    if (sel[k]) ref_ram[ea[7:2]][k*8 +: 8] = d[k*8 +: 8];
                end
            end
            op_beq: if (a == b) next = npc + {sx[29:0], 2'b00};
            op_bne: if (a != b) next = npc + {sx[29:0], 2'b00};
            default: ;
        endcase
        regs[0] = '0;
        pc = npc;
        npc = next;
        ref_steps++;
    end
endfunction

`endif

// ==== test/tb_openmips.sv ====
`timescale 1ns/1ps

module tb_openmips;
    import isa_pkg::*;

    localparam logic [31:0] reset_pc  = 32'h0000_0100;
    localparam int          rom_depth = 256;
    localparam int          ram_depth = 64;
    localparam int          reset_cycles = 10;

    logic        clk;
    logic        reset_i;
    logic [31:0] rom_data_i;
    logic [31:0] ram_data_i;
    logic        rom_ce_o;
    logic [31:0] rom_addr_o;
    logic        ram_ce_o;
    logic        ram_we_o;
    logic [3:0]  ram_sel_o;
    logic [31:0] ram_addr_o;
    logic [31:0] ram_wdata_o;
    logic [31:0] rom [rom_depth];
    logic [31:0] ram [ram_depth];
    string       test_name;
    int          store_errors;
    int          other_errors;
    int          exp_idx;
    int          halt_seen;
    int          cycles;
    int          limit;
    logic        first_fetch;
    logic        reset_q;
    logic        timed_out;

    `include "tb_ref_model.svh"

    openmips #(.reset_pc(reset_pc)) u_openmips (
        .clk(clk), .reset_i(reset_i), .rom_data_i(rom_data_i), .ram_data_i(ram_data_i),
        .rom_ce_o(rom_ce_o), .rom_addr_o(rom_addr_o), .ram_ce_o(ram_ce_o),
        .ram_we_o(ram_we_o), .ram_sel_o(ram_sel_o), .ram_addr_o(ram_addr_o),
        .ram_wdata_o(ram_wdata_o)
    );

    assign rom_data_i = rom[rom_addr_o[9:2]];
    assign ram_data_i = ram[ram_addr_o[7:2]];

    always #5 clk = ~clk;

    // store monitor and ram write port
    always @(posedge clk) begin
        reset_q <= reset_i;
        if (reset_i) begin
            exp_idx <= 0;
            halt_seen <= 0;
            cycles <= 0;
            first_fetch <= 1'b1;
            // enables clear at the first reset edge
            if (reset_q && (rom_ce_o || ram_ce_o || ram_we_o)) begin
                $display("memory enable active during reset in %s", test_name);
                other_errors++;
            end
        end else begin
            cycles <= cycles + 1;
            if (rom_ce_o && first_fetch) begin
                first_fetch <= 1'b0;
                if (rom_addr_o != reset_pc) begin
                    $display("error %s reset fetch expected %h actual %h",
                             test_name, reset_pc, rom_addr_o);
                    store_errors++;
                end
            end
            if (rom_ce_o && rom_addr_o == halt_pc) halt_seen <= halt_seen + 1;
            if (ram_ce_o && ram_we_o) begin
                for (int k = 0; k < 4; k++) begin
                    if (ram_sel_o[k]) ram[ram_addr_o[7:2]][k*8 +: 8] <= ram_wdata_o[k*8 +: 8];
                end
                if (exp_idx >= exp_q.size()) begin
                    $display("unexpected extra store to %h in %s", ram_addr_o, test_name);
                    other_errors++;
                end else if ({ram_addr_o, ram_sel_o, ram_wdata_o} != exp_q[exp_idx]) begin
                    $display("error %s store %0d expected %h actual %h", test_name, exp_idx,
                             exp_q[exp_idx], {ram_addr_o, ram_sel_o, ram_wdata_o});
                    store_errors++;
                end
                exp_idx <= exp_idx + 1;
            end
        end
    end

    task automatic build_alu_chain();
        logic [3:0]  kind;
        logic [4:0]  prev;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int r = 1; r < 8; r++) begin
            emit(enc_i(op_ori, 5'd0, 5'(r), 16'(rand_bits(16))));
        end
        prev = 5'd1;
        for (int n = 0; n < 40; n++) begin
            kind = 4'(rand_bits(4) % 10);
            rd = pick_reg();
            imm = 16'(rand_bits(16));
            case (kind)
                4'd0: emit(enc_r(fn_addu, prev, pick_reg(), rd));
                4'd1: emit(enc_r(fn_subu, prev, pick_reg(), rd));
                4'd2: emit(enc_r(fn_and, prev, pick_reg(), rd));
                4'd3: emit(enc_r(fn_or, prev, pick_reg(), rd));
                4'd4: emit(enc_r(fn_xor, pick_reg(), prev, rd));
                4'd5: emit(enc_r(fn_slt, prev, pick_reg(), rd));
                4'd6: emit(enc_i(op_addiu, prev, rd, imm));
                4'd7: emit(enc_i(op_andi, prev, rd, imm));
                4'd8: emit(enc_i(op_ori, prev, rd, imm));
                default: emit(enc_i(op_lui, 5'd0, rd, imm));
            endcase
            prev = rd;   // next op reads this result
        end
        for (int r = 1; r < 8; r++) begin
            emit(enc_i(op_sw, 5'd0, 5'(r), 16'(r * 4)));
        end
    endtask

    task automatic build_load_use();
        emit(enc_i(op_addiu, 5'd0, 5'd1, 16'h0040));
        emit(enc_i(op_ori, 5'd0, 5'd2, 16'h1234));
        emit(enc_i(op_sw, 5'd1, 5'd2, 16'd0));
        emit(enc_i(op_lw, 5'd1, 5'd3, 16'd0));
        emit(enc_r(fn_addu, 5'd3, 5'd3, 5'd4));
        emit(enc_i(op_sw, 5'd1, 5'd4, 16'd4));
        emit(enc_i(op_lw, 5'd1, 5'd5, 16'd0));
        emit(enc_i(op_beq, 5'd5, 5'd2, 16'd2));
        emit(enc_i(op_addiu, 5'd0, 5'd6, 16'd7));
        emit(enc_i(op_sw, 5'd1, 5'd6, 16'd8));
        emit(enc_i(op_sw, 5'd1, 5'd6, 16'd12));
        emit(enc_i(op_lw, 5'd1, 5'd7, 16'd4));
        emit(enc_i(op_sw, 5'd1, 5'd7, 16'd16));
    endtask

    task automatic build_byte_access();
        emit(enc_i(op_addiu, 5'd0, 5'd2, 16'h00a5));
        emit(enc_i(op_addiu, 5'd0, 5'd3, 16'h005a));
        emit(enc_i(op_sb, 5'd0, 5'd2, 16'h0080));
        emit(enc_i(op_sb, 5'd0, 5'd3, 16'h0081));
        emit(enc_i(op_sb, 5'd0, 5'd3, 16'h0082));
        emit(enc_i(op_sb, 5'd0, 5'd2, 16'h0083));
        emit(enc_i(op_lb, 5'd0, 5'd4, 16'h0080));
        emit(enc_i(op_sw, 5'd0, 5'd4, 16'h0090));
        emit(enc_i(op_lb, 5'd0, 5'd5, 16'h0081));
        emit(enc_i(op_sw, 5'd0, 5'd5, 16'h0094));
        emit(enc_i(op_lb, 5'd0, 5'd6, 16'h0083));
        emit(enc_i(op_sw, 5'd0, 5'd6, 16'h0098));
        emit(enc_i(op_lw, 5'd0, 5'd7, 16'h0080));
        emit(enc_i(op_sw, 5'd0, 5'd7, 16'h009c));
    endtask

    task automatic build_branches();
        emit(enc_i(op_addiu, 5'd0, 5'd1, 16'd5));
        emit(enc_i(op_addiu, 5'd0, 5'd2, 16'd5));
        emit(enc_i(op_beq, 5'd1, 5'd2, 16'd2));   // taken with r2 from ex
        emit(enc_i(op_sw, 5'd0, 5'd1, 16'h00a0));
        emit(enc_i(op_sw, 5'd0, 5'd2, 16'h00a4));
        emit(enc_i(op_bne, 5'd1, 5'd2, 16'd2));
        emit(enc_i(op_sw, 5'd0, 5'd2, 16'h00a8));
        emit(enc_i(op_sw, 5'd0, 5'd1, 16'h00ac));
        emit(enc_i(op_addiu, 5'd0, 5'd3, 16'd6));
        emit(enc_i(op_addiu, 5'd0, 5'd4, 16'd1));
        emit(enc_i(op_bne, 5'd4, 5'd3, 16'd2));
        emit(enc_i(op_sw, 5'd0, 5'd3, 16'h00b0));
        emit(enc_i(op_sw, 5'd0, 5'd4, 16'h00b4));
        emit(enc_i(op_beq, 5'd1, 5'd3, 16'd2));
        emit(enc_i(op_sw, 5'd0, 5'd4, 16'h00b8));
        emit(enc_i(op_sw, 5'd0, 5'd3, 16'h00bc));
    endtask

    task automatic run_program(string name, int kind);
        if (timed_out) return;
        @(posedge clk);
        reset_i <= 1'b1;
        @(posedge clk);
        test_name = name;
        prog_len = 0;
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = '0;
        end
        case (kind)
            0: build_alu_chain();
            1: build_load_use();
            2: build_byte_access();
            default: build_branches();
        endcase
        emit_halt();
        for (int i = 0; i < ram_depth; i++) begin
            ram[i] = 32'(i) * 32'h9e3779b1 ^ 32'h5a5a0000;
            ref_ram[i] = ram[i];
        end
        run_reference();
        limit = 5 * ref_steps + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        while (halt_seen < 3 && cycles <= limit) @(posedge clk);
        if (cycles > limit) begin
            $display("timeout in %s, halt loop not reached after %0d cycles", name, cycles);
            other_errors++;
            timed_out = 1'b1;
        end else if (exp_idx != exp_q.size()) begin
            $display("%s reached halt after %0d of %0d stores", name, exp_idx, exp_q.size());
            other_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        test_name = "reset";
        store_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;
        halt_pc = '1;
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < ram_depth; i++) begin
            ram[i] = '0;
        end
        run_program("alu_chain_a", 0);
        run_program("alu_chain_b", 0);
        run_program("alu_chain_c", 0);
        run_program("load_use", 1);
        run_program("byte_access", 2);
        run_program("branches", 3);
        $display("store errors %0d, other errors %0d", store_errors, other_errors);
        if (store_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
